// File: shadow_check_top.f
logic/shadow_pkg.sv
logic/session_ctrl.sv
logic/impl_buffer.sv
logic/golden_buffer.sv
logic/mismatch_scan.sv
logic/shadow_check_top.sv
tests/shadow_check_props.sv
tests/shadow_check_tb.sv

// File: tests/shadow_check_stimulus.txt
# op a b c, all hex; iwr/gwr: a address, b data; gwr c=1 also steps in that cycle
# start/finish c=1: impl write of a,b in the same cycle; idle a: cycles; expect a count, b first, c flag
# matching writes on both sides
start 0 0 0
iwr 10 a5 0
gwr 10 a5 0
step 0 0 0
iwr 11 3c 0
gwr 11 3c 1
idle 2 0 0
finish 0 0 0
expect 0 0 0
# writes outside the window
reset 0 0 0
iwr 20 77 0
start 21 55 1
gwr 30 11 1
iwr 30 11 0
finish 22 99 1
expect 1 21 1
# golden commit rules
reset 0 0 0
start 0 0 0
gwr 40 12 0
gwr 40 34 0
step 0 0 0
iwr 40 34 0
gwr 41 56 0
iwr 41 56 0
gwr 42 78 0
step 0 0 0
iwr 42 78 0
gwr 43 9a 0
gwr 44 bc 1
iwr 44 bc 0
finish 0 0 0
expect 1 41 1
# several mismatches, then a second start and finish
reset 0 0 0
start 0 0 0
iwr 50 01 0
iwr 1ff ee 0
iwr 60 02 0
gwr 60 03 1
gwr 70 04 1
iwr 70 04 0
gwr 5 aa 1
finish 0 0 0
expect 4 5 1
start 0 0 0
finish 0 0 0
idle 258 0 0
# reset clears both buffers
reset 0 0 0
start 0 0 0
finish 0 0 0
expect 0 0 0

// File: tests/shadow_check_tb.sv
`default_nettype none

module shadow_check_tb import shadow_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int TIMEOUT = 2000;

  logic clk;
  logic rst;
  logic start;
  logic finish;
  logic impl_wen;
  logic [ADDR_W-1:0] impl_addr;
  logic [DATA_W-1:0] impl_data;
  logic gold_wen;
  logic [ADDR_W-1:0] gold_addr;
  logic [DATA_W-1:0] gold_data;
  logic step;
  logic recording;
  logic result_valid;
  logic [COUNT_W-1:0] mismatch_count;
  logic [ADDR_W-1:0] first_addr;
  logic mismatch;

  // reference model state
  logic [DATA_W-1:0] m_impl [DEPTH];
  logic [DATA_W-1:0] m_gold [DEPTH];
  // session phase, 0 before start, 1 recording, 2 after finish
  int m_phase;
  logic m_pend_valid;
  logic [ADDR_W-1:0] m_pend_addr;
  logic [DATA_W-1:0] m_pend_data;

  int cyc = 0;
  int finish_cyc;
  logic finish_seen;
  int value_errors;
  int other_errors;
  int fd;
  int n;
  logic done;
  logic [63:0] op;
  logic [8*128-1:0] rest;
  logic [31:0] fa;
  logic [31:0] fb;
  logic [31:0] fc;

  shadow_check_top UUT (
    .clk(clk), .rst(rst), .start(start), .finish(finish),
    .impl_wen(impl_wen), .impl_addr(impl_addr), .impl_data(impl_data),
    .gold_wen(gold_wen), .gold_addr(gold_addr), .gold_data(gold_data), .step(step),
    .recording(recording), .result_valid(result_valid),
    .mismatch_count(mismatch_count), .first_addr(first_addr), .mismatch(mismatch)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL %0t %s: got %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic set_inputs(input logic s, input logic f, input logic iw,
                            input logic [ADDR_W-1:0] ia, input logic [DATA_W-1:0] id,
                            input logic gw, input logic [ADDR_W-1:0] ga,
                            input logic [DATA_W-1:0] gd, input logic st);
    start = s;
    finish = f;
    impl_wen = iw;
    impl_addr = ia;
    impl_data = id;
    gold_wen = gw;
    gold_addr = ga;
    gold_data = gd;
    step = st;
  endtask

  task automatic run_reset();
    @(negedge clk);
    rst = 1'b1;
    set_inputs(1'b0, 1'b0, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0);
    repeat (5) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      m_impl[i] = '0;
      m_gold[i] = '0;
    end
    m_phase = 0;
    m_pend_valid = 1'b0;
    finish_seen = 1'b0;
  endtask

  // one cycle of stimulus, then the model steps to the next rising edge
  task automatic drive_cycle(input logic s, input logic f, input logic iw,
                             input logic [ADDR_W-1:0] ia, input logic [DATA_W-1:0] id,
                             input logic gw, input logic [ADDR_W-1:0] ga,
                             input logic [DATA_W-1:0] gd, input logic st);
    logic exp_window;
    logic finish_counts;
    @(negedge clk);
    set_inputs(s, f, iw, ia, id, gw, ga, gd, st);
    // window opens with the start cycle and closes with the finish cycle
    case (m_phase)
      0: exp_window = s;
      1: exp_window = !f;
      default: exp_window = 1'b0;
    endcase
    finish_counts = (m_phase == 1) && f;
    #(CLK_PERIOD / 4);
    check("recording", 32'(recording), 32'(exp_window));
    check("result_valid", 32'(result_valid), 32'(1'b0));
    if (exp_window && iw) m_impl[ia] = id;
    if (st) begin
      if (gw) m_gold[ga] = gd;
      else if (m_pend_valid) m_gold[m_pend_addr] = m_pend_data;
      m_pend_valid = 1'b0;
    end else if (gw) begin
      m_pend_addr = ga;
      m_pend_data = gd;
      m_pend_valid = 1'b1;
    end
    if (m_phase == 0 && s) m_phase = 1;
    if (finish_counts) begin
      m_phase = 2;
      finish_seen = 1'b1;
      finish_cyc = cyc;
    end
  endtask

  task automatic wait_result(input logic [31:0] f_count, input logic [31:0] f_first,
                             input logic [31:0] f_flag);
    int m_count;
    int m_first;
    int waited;
    logic got;
    m_count = 0;
    m_first = 0;
    for (int i = 0; i < DEPTH; i++) begin
      if (m_impl[i] !== m_gold[i]) begin
        if (m_count == 0) m_first = i;
        m_count++;
      end
    end
    check("stimulus count", f_count, m_count);
    check("stimulus first address", f_first, m_first);
    check("stimulus flag", f_flag, 32'(m_count != 0));
    waited = 0;
    got = 1'b0;
    while (!got && waited < TIMEOUT) begin
      @(negedge clk);
      set_inputs(1'b0, 1'b0, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0);
      if (result_valid) got = 1'b1;
      else waited++;
    end
    if (!got) begin
      other_errors++;
      $display("timed out after %0d cycles waiting for result_valid", TIMEOUT);
    end else begin
      check("mismatch_count", 32'(mismatch_count), m_count);
      check("first_addr", 32'(first_addr), m_first);
      check("mismatch", 32'(mismatch), 32'(m_count != 0));
      if (finish_seen) check("result latency", cyc - finish_cyc, DEPTH + 2);
      else begin
        other_errors++;
        $display("result_valid arrived without a counted finish");
      end
    end
    finish_seen = 1'b0;
  endtask

  task automatic run_op(input logic [63:0] name, input logic [31:0] a,
                        input logic [31:0] b, input logic [31:0] c);
    if (name == "reset") run_reset();
    else if (name == "start")
      drive_cycle(1'b1, 1'b0, c[0], a[ADDR_W-1:0], b[DATA_W-1:0], 1'b0, '0, '0, 1'b0);
    else if (name == "finish")
      drive_cycle(1'b0, 1'b1, c[0], a[ADDR_W-1:0], b[DATA_W-1:0], 1'b0, '0, '0, 1'b0);
    else if (name == "iwr")
      drive_cycle(1'b0, 1'b0, 1'b1, a[ADDR_W-1:0], b[DATA_W-1:0], 1'b0, '0, '0, 1'b0);
    else if (name == "gwr")
      drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, 1'b1, a[ADDR_W-1:0], b[DATA_W-1:0], c[0]);
    else if (name == "step")
      drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, 1'b0, '0, '0, 1'b1);
    else if (name == "idle")
      repeat (a) drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0);
    else if (name == "expect") wait_result(a, b, c);
    else begin
      other_errors++;
      $display("unknown operation %0s in stimulus file", name);
    end
  endtask

  initial begin
    rst = 1'b1;
    set_inputs(1'b0, 1'b0, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0);
    value_errors = 0;
    other_errors = 0;
    finish_cyc = 0;
    run_reset();
    fd = $fopen("tests/shadow_check_stimulus.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open tests/shadow_check_stimulus.txt");
    end else begin
      done = 1'b0;
      while (!done) begin
        n = $fscanf(fd, "%s", op);
        if (n != 1) done = 1'b1;
        else if (op == "#") n = $fgets(rest, fd);
        else begin
          n = $fscanf(fd, "%h %h %h", fa, fb, fc);
          if (n != 3) begin
            other_errors++;
            $display("operation %0s is missing its fields", op);
            done = 1'b1;
          end else run_op(op, fa, fb, fc);
        end
      end
      $fclose(fd);
    end
    drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0);
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/shadow_check_props.sv
`default_nettype none

module session_props (
  input logic clk,
  input logic rst,
  input logic window,
  input logic compare
);

  logic compared;

  // set by the first compare, cleared only by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      compared <= 1'b0;
    end else if (compare) begin
      compared <= 1'b1;
    end
  end

  compare_one_cycle: assert property (@(posedge clk) disable iff (rst) compare |=> !compare)
    else $error("compare high in two consecutive cycles");

  window_compare_apart: assert property (@(posedge clk) disable iff (rst) !(window && compare))
    else $error("window and compare high together");

  no_reopen: assert property (@(posedge clk) disable iff (rst) compared |-> !window)
    else $error("window open again after compare");

endmodule

bind session_ctrl session_props u_props (
  .clk     (clk),
  .rst     (rst),
  .window  (window),
  .compare (compare)
);

`default_nettype wire

// File: logic/shadow_check_top.sv
`default_nettype none

module shadow_check_top import shadow_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               finish,
  input  logic               impl_wen,
  input  logic [ADDR_W-1:0]  impl_addr,
  input  logic [DATA_W-1:0]  impl_data,
  input  logic               gold_wen,
  input  logic [ADDR_W-1:0]  gold_addr,
  input  logic [DATA_W-1:0]  gold_data,
  input  logic               step,
  output logic               recording,
  output logic               result_valid,
  output logic [COUNT_W-1:0] mismatch_count,
  output logic [ADDR_W-1:0]  first_addr,
  output logic               mismatch
);

  logic              window;
  logic              compare;
  logic [ADDR_W-1:0] scan_addr;
  logic [DATA_W-1:0] impl_rdata;
  logic [DATA_W-1:0] gold_rdata;

  session_ctrl u_session (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .finish  (finish),
    .window  (window),
    .compare (compare)
  );

  assign recording = window;

  impl_buffer u_impl (
    .clk       (clk),
    .rst       (rst),
    .window    (window),
    .impl_wen  (impl_wen),
    .impl_addr (impl_addr),
    .impl_data (impl_data),
    .scan_addr (scan_addr),
    .rdata     (impl_rdata)
  );

  golden_buffer u_gold (
    .clk       (clk),
    .rst       (rst),
    .gold_wen  (gold_wen),
    .gold_addr (gold_addr),
    .gold_data (gold_data),
    .step      (step),
    .scan_addr (scan_addr),
    .rdata     (gold_rdata)
  );

  // both buffers share one scan address
  mismatch_scan u_scan (
    .clk            (clk),
    .rst            (rst),
    .compare        (compare),
    .impl_rdata     (impl_rdata),
    .gold_rdata     (gold_rdata),
    .scan_addr      (scan_addr),
    .result_valid   (result_valid),
    .mismatch_count (mismatch_count),
    .first_addr     (first_addr),
    .mismatch       (mismatch)
  );

endmodule

`default_nettype wire

// File: logic/mismatch_scan.sv
`default_nettype none

module mismatch_scan import shadow_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               compare,
  input  logic [DATA_W-1:0]  impl_rdata,
  input  logic [DATA_W-1:0]  gold_rdata,
  output logic [ADDR_W-1:0]  scan_addr,
  output logic               result_valid,
  output logic [COUNT_W-1:0] mismatch_count,
  output logic [ADDR_W-1:0]  first_addr,
  output logic               mismatch
);

  logic               busy;
  logic               launch;
  logic               chk_valid;
  logic               chk_last;
  logic [ADDR_W-1:0]  chk_addr;
  logic               diff;
  logic [COUNT_W-1:0] run_count;
  logic [COUNT_W-1:0] next_count;
  logic               run_found;
  logic [ADDR_W-1:0]  run_first;

  // a compare during a scan or its last check is ignored
  assign launch = compare & ~busy & ~chk_valid;

  // read data belongs to the address issued one cycle earlier
  assign diff       = chk_valid & (impl_rdata != gold_rdata);
  assign next_count = run_count + {{(COUNT_W-1){1'b0}}, diff};

  // address issue, one per cycle from 0 to the last entry
  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      scan_addr <= '0;
    end else if (launch) begin
      busy      <= 1'b1;
      scan_addr <= '0;
    end else if (busy) begin
      scan_addr <= scan_addr + 1'b1;
      if (scan_addr == LAST_ADDR) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      chk_valid <= 1'b0;
      chk_last  <= 1'b0;
    end else begin
      chk_valid <= busy;
      chk_last  <= busy & (scan_addr == LAST_ADDR);
    end
  end

  always_ff @(posedge clk) begin
    chk_addr <= scan_addr;
  end

  // running count and lowest differing address
  always_ff @(posedge clk) begin
    if (rst) begin
      run_count <= '0;
      run_found <= 1'b0;
    end else if (launch) begin
      run_count <= '0;
      run_found <= 1'b0;
    end else if (diff) begin
      run_count <= next_count;
      run_found <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (diff && !run_found) begin
      run_first <= chk_addr;
    end
  end

  // results load on the last check and hold until the next scan
  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid   <= 1'b0;
      mismatch_count <= '0;
      first_addr     <= '0;
      mismatch       <= 1'b0;
    end else begin
      result_valid <= chk_last;
      if (chk_last) begin
        mismatch_count <= next_count;
        mismatch       <= (next_count != '0);
        if (run_found) begin
          first_addr <= run_first;
        end else if (diff) begin
          first_addr <= chk_addr;
        end else begin
          first_addr <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/golden_buffer.sv
`default_nettype none

module golden_buffer import shadow_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              gold_wen,
  input  logic [ADDR_W-1:0] gold_addr,
  input  logic [DATA_W-1:0] gold_data,
  input  logic              step,
  input  logic [ADDR_W-1:0] scan_addr,
  output logic [DATA_W-1:0] rdata
);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [DEPTH-1:0]  valid;
  logic              pend_valid;
  logic [ADDR_W-1:0] pend_addr;
  logic [DATA_W-1:0] pend_data;
  logic              commit;
  logic [ADDR_W-1:0] commit_addr;
  logic [DATA_W-1:0] commit_data;

  // a request in the step cycle bypasses the slot
  assign commit      = step & (gold_wen | pend_valid);
  assign commit_addr = gold_wen ? gold_addr : pend_addr;
  assign commit_data = gold_wen ? gold_data : pend_data;

  // single pending slot, newest request wins
  always_ff @(posedge clk) begin
    if (gold_wen) begin
      pend_addr <= gold_addr;
      pend_data <= gold_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_valid <= 1'b0;
    end else if (step) begin
      pend_valid <= 1'b0;
    end else if (gold_wen) begin
      pend_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (commit) begin
      mem[commit_addr] <= commit_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (commit) begin
      valid[commit_addr] <= 1'b1;
    end
  end

  // read side matches the implementation shadow
  always_ff @(posedge clk) begin
    rdata <= valid[scan_addr] ? mem[scan_addr] : '0;
  end

endmodule

`default_nettype wire

// File: logic/impl_buffer.sv
`default_nettype none

module impl_buffer import shadow_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              window,
  input  logic              impl_wen,
  input  logic [ADDR_W-1:0] impl_addr,
  input  logic [DATA_W-1:0] impl_data,
  input  logic [ADDR_W-1:0] scan_addr,
  output logic [DATA_W-1:0] rdata
);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [DEPTH-1:0]  valid;
  logic              wr_en;

  // writes outside the recording window are dropped
  assign wr_en = window & impl_wen;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[impl_addr] <= impl_data;
    end
  end

  // per-entry written flags
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[impl_addr] <= 1'b1;
    end
  end

  // registered read, unwritten entries give zero
  always_ff @(posedge clk) begin
    if (valid[scan_addr]) begin
      rdata <= mem[scan_addr];
    end else begin
      rdata <= '0;
    end
  end

endmodule

`default_nettype wire

// File: logic/session_ctrl.sv
`default_nettype none

module session_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic finish,
  output logic window,
  output logic compare
);

  logic started;
  logic finished;
  logic start_hit;
  logic finish_hit;

  // only the first start after reset counts
  assign start_hit = start & ~started;

  // finish needs an earlier start and fires once
  assign finish_hit = finish & started & ~finished;

  always_ff @(posedge clk) begin
    if (rst) begin
      started <= 1'b0;
    end else if (start_hit) begin
      started <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      finished <= 1'b0;
    end else if (finish_hit) begin
      finished <= 1'b1;
    end
  end

  // open from the start cycle, closed from the finish cycle on
  assign window = (start_hit | started) & ~(finish_hit | finished);

  // one cycle, the cycle the finish counts
  assign compare = finish_hit;

endmodule

`default_nettype wire

// File: logic/shadow_pkg.sv
`default_nettype none

package shadow_pkg;

  // buffer geometry
  localparam int ADDR_W = 9;
  localparam int DATA_W = 8;

  // one entry per address
  localparam int DEPTH = 1 << ADDR_W;

  // one extra bit so a full mismatch of every entry still fits
  localparam int COUNT_W = ADDR_W + 1;

  // final address of a scan
  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);

endpackage

`default_nettype wire
